// File: Bender.yml
package:
  name: mempool_system

export_include_dirs:
  - include

sources:
  # packages first, then the design bottom-up
  - verilog/mempool_bus_pkg.sv
  - verilog/mempool_ctrl_pkg.sv
  - verilog/mempool_rr_arbiter.sv
  - verilog/mempool_interconnect.sv
  - verilog/mempool_l2_mem.sv
  - verilog/mempool_ctrl_registers.sv
  - verilog/mempool_system.sv
  - target: test
    files:
      - bench/mempool_system_props.sv
      - bench/tb_mempool_system.sv

// File: bench/mempool_system_props.sv
`timescale 1ns/1ps
`include "mempool_cfg.svh"

module mempool_system_props (
  input logic                                       clk_i,
  input logic                                       reset_i,
  input logic                      [`NUM_TILES-1:0] tile_gnt_o,
  input logic                                       host_gnt_o,
  input mempool_bus_pkg::bus_rsp_t [`NUM_TILES-1:0] tile_rsp_o,
  input mempool_bus_pkg::bus_rsp_t                  host_rsp_o,
  input logic                      [`NUM_CORES-1:0] wake_up_o,
  input logic                                       eoc_valid_o
);

  logic [`NUM_TILES:0] gnt;
  logic [`NUM_TILES:0] rvalid;
  int unsigned         fail_count = 0;

  assign gnt = {host_gnt_o, tile_gnt_o};  // host is the top master, as in the system

  always_comb begin
    for (int i = 0; i < `NUM_TILES; i++) begin
      rvalid[i] = tile_rsp_o[i].rvalid;
    end
    rvalid[`NUM_TILES] = host_rsp_o.rvalid;
  end

  gnt_onehot: assert property (@(posedge clk_i) disable iff (reset_i) $onehot0(gnt))
    else begin
      $error("more than one master granted in the same cycle");
      fail_count++;
    end

  rvalid_after_gnt: assert property (@(posedge clk_i) disable iff (reset_i)
    !$past(reset_i) |-> (rvalid == $past(gnt)))
    else begin
      $error("rvalid does not follow the grant of the previous cycle");
      fail_count++;
    end

  wake_up_single: assert property (@(posedge clk_i) disable iff (reset_i)
    (|wake_up_o) |=> !(|wake_up_o))
    else begin
      $error("wake_up_o stayed high for two cycles");
      fail_count++;
    end

  eoc_sticky: assert property (@(posedge clk_i) disable iff (reset_i) !$fell(eoc_valid_o))
    else begin
      $error("eoc_valid_o fell outside reset");
      fail_count++;
    end

endmodule

bind mempool_system mempool_system_props i_props (.*);

// File: bench/tb_mempool_system.sv
`timescale 1ns/1ps
`include "mempool_cfg.svh"

module tb_mempool_system;

  localparam int unsigned NUM_MST    = `NUM_TILES + 1;
  localparam int unsigned HOST       = `NUM_TILES;
  localparam logic [31:0] EXT_KEY    = 32'h5A5A_C3C3;
  localparam int unsigned GNT_LIMIT  = 100;
  // budgets of tests 1 to 5 in cycles, then reset and margin
  localparam int unsigned RUN_CYCLES = 80 + 30 + 40 + 80 + 600 + 100;

  logic                                    clk;
  logic                                    reset;
  logic                                    fetch_en;
  logic                                    ext_gnt;
  logic [31:0]                             ext_rdata;
  mempool_bus_pkg::bus_req_t [NUM_MST-1:0] mst_req;
  wire [NUM_MST-1:0]                       mst_gnt;
  wire mempool_bus_pkg::bus_rsp_t [NUM_MST-1:0] mst_rsp;
  mempool_bus_pkg::bus_req_t               ext_req;
  logic [`NUM_CORES-1:0]                   wake_up;
  logic [31:0]                             eoc;
  logic                                    eoc_valid;
  logic                                    busy;

  logic [31:0]               l2_shadow [`L2_WORDS];
  logic [31:0]               eoc_shadow;
  logic [31:0]               exp_q [NUM_MST][$];
  int unsigned               grant_wait [NUM_MST];
  mempool_bus_pkg::bus_req_t ext_seen;
  logic                      ext_hit;
  logic                      ext_random;
  int unsigned               ext_low_cycles;
  int unsigned               errors;
  int unsigned               tests_passed;
  int unsigned               tests_failed;

  mempool_system i_dut (
    .clk_i      (clk),
    .reset_i    (reset),
    .fetch_en_i (fetch_en),
    .tile_req_i (mst_req[NUM_MST-2:0]),
    .tile_gnt_o (mst_gnt[NUM_MST-2:0]),
    .tile_rsp_o (mst_rsp[NUM_MST-2:0]),
    .host_req_i (mst_req[HOST]),
    .host_gnt_o (mst_gnt[HOST]),
    .host_rsp_o (mst_rsp[HOST]),
    .ext_req_o  (ext_req),
    .ext_gnt_i  (ext_gnt),
    .ext_rdata_i(ext_rdata),
    .wake_up_o  (wake_up),
    .eoc_o      (eoc),
    .eoc_valid_o(eoc_valid),
    .busy_o     (busy)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // **********************************************************************
  // external port model
  // **********************************************************************

  always @(posedge clk) begin
    if (ext_req.req && ext_gnt) begin
      ext_seen <= ext_req;
    end
    ext_hit <= ext_req.req && ext_gnt;
  end

  always @(negedge clk) begin
    ext_rdata = ext_hit ? (ext_seen.addr ^ EXT_KEY) : $urandom;  // junk when idle
    if (ext_low_cycles > 0) begin
      ext_gnt = 1'b0;
      ext_low_cycles--;
    end else begin
      ext_gnt = ext_random ? $urandom_range(0, 1) : 1'b1;
    end
  end

  function automatic mempool_bus_pkg::bus_req_t make_req(input logic we, input logic [3:0] be,
                                                         input logic [31:0] addr,
                                                         input logic [31:0] wdata);
    mempool_bus_pkg::bus_req_t r;
    r.req   = 1'b1;
    r.we    = we;
    r.be    = be;
    r.addr  = addr;
    r.wdata = wdata;
    return r;
  endfunction

  // expected rdata from the address map and the shadow state
  function automatic logic [31:0] ref_rdata(input mempool_bus_pkg::bus_req_t r);
    logic [31:0] a;
    a = r.addr;
    if (r.we) begin
      return '0;
    end
    if (a >= `CTRL_BASE && a <= `CTRL_END) begin
      case (a[4:2])
        mempool_ctrl_pkg::REG_TCDM_START: return `TCDM_BASE;
        mempool_ctrl_pkg::REG_TCDM_END:   return `TCDM_BASE + `TCDM_SIZE - 1;
        mempool_ctrl_pkg::REG_NUM_CORES:  return `NUM_CORES;
        mempool_ctrl_pkg::REG_EOC:        return eoc_shadow;
        default:                          return '0;
      endcase
    end
    if (a >= `L2_BASE && a <= `L2_END) begin
      return l2_shadow[((a - `L2_BASE) >> 2) % `L2_WORDS];
    end
    return a ^ EXT_KEY;
  endfunction

  task automatic ref_update(input mempool_bus_pkg::bus_req_t r);
    logic [31:0] a;
    a = r.addr;
    if (!r.we) begin
      return;
    end
    if (a >= `CTRL_BASE && a <= `CTRL_END) begin
      if (a[4:2] == mempool_ctrl_pkg::REG_EOC) begin
        eoc_shadow = r.wdata;
      end
    end else if (a >= `L2_BASE && a <= `L2_END) begin
      for (int b = 0; b < 4; b++) begin
        if (r.be[b]) begin
          l2_shadow[((a - `L2_BASE) >> 2) % `L2_WORDS][8*b +: 8] = r.wdata[8*b +: 8];
        end
      end
    end
  endtask

  task automatic check_value(input string what, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp) else begin
      $display("Mismatch at %0d ns: %s is %h, expected %h", $time, what, got, exp);
      errors++;
    end
  endtask

  // drives one access from the current falling edge and waits for its grant
  task automatic bus_access(input int unsigned m, input logic we, input logic [3:0] be,
                            input logic [31:0] addr, input logic [31:0] wdata);
    mempool_bus_pkg::bus_req_t r;
    int unsigned               others;
    r             = make_req(we, be, addr, wdata);
    others        = 0;
    grant_wait[m] = 0;
    mst_req[m]    = r;
    @(posedge clk);
    while (!mst_gnt[m] && grant_wait[m] < GNT_LIMIT) begin
      others += $countones(mst_gnt);
      grant_wait[m]++;
      @(posedge clk);
    end
    assert (mst_gnt[m]) else begin
      $display("master %0d got no grant within %0d cycles", m, GNT_LIMIT);
      errors++;
    end
    assert (others <= `NUM_TILES) else begin
      $display("master %0d waited through %0d grants to other masters", m, others);
      errors++;
    end
    if (mst_gnt[m]) begin
      exp_q[m].push_back(ref_rdata(r));
      ref_update(r);
    end
    @(negedge clk);
    mst_req[m].req = 1'b0;
  endtask

  task automatic random_traffic(input int unsigned m, input int unsigned count);
    logic [31:0] addr;
    logic [3:0]  be;
    logic        we;
    repeat (count) begin
      we = $urandom_range(0, 1);
      be = $urandom_range(1, 15);
      case ($urandom_range(0, 2))
        // upper index bits are random so the L2 window wraps onto 16 written words
        0: addr = `L2_BASE | ($urandom & 32'h3FFF_FC00) | ($urandom_range(0, 15) << 2);
        1: begin
          addr = `CTRL_BASE | ($urandom & 32'h0000_FFE0) | ($urandom_range(0, 7) << 2);
          we   = 1'b0;
        end
        default: addr = {2'b00, 30'($urandom)};
      endcase
      bus_access(m, we, be, addr, $urandom);
    end
  endtask

  task automatic finish_test(input string name, input int unsigned mark);
    int unsigned pending;
    int unsigned cycles;
    cycles = 0;
    do begin
      @(negedge clk);
      pending = 0;
      for (int m = 0; m < NUM_MST; m++) begin
        pending += exp_q[m].size();
      end
      cycles++;
    end while (pending != 0 && cycles < 20);
    assert (pending == 0) else begin
      $display("%0d responses never arrived", pending);
      errors++;
    end
    if (errors == mark) begin
      tests_passed++;
      $display("%s: ok", name);
    end else begin
      tests_failed++;
      $display("%s: %0d errors", name, errors - mark);
    end
  endtask

  // **********************************************************************
  // response comparison
  // **********************************************************************

  always @(posedge clk) begin
    if (!reset) begin
      for (int m = 0; m < NUM_MST; m++) begin
        if (mst_rsp[m].rvalid) begin
          assert (exp_q[m].size() != 0) else begin
            $display("master %0d got a response it never asked for", m);
            errors++;
          end
          if (exp_q[m].size() != 0) begin
            check_value($sformatf("master %0d rdata", m), mst_rsp[m].rdata, exp_q[m].pop_front());
          end
        end
      end
    end
  end

  initial begin
    repeat (RUN_CYCLES) @(posedge clk);
    $display("watchdog expired after %0d cycles, the run is stuck", RUN_CYCLES);
    $display("TEST FAIL");
    $finish;
  end

  initial begin
    int unsigned mark;
    void'($urandom(32'h4573_78f9));
    reset          = 1'b1;
    fetch_en       = 1'b0;
    mst_req        = '0;
    ext_gnt        = 1'b1;
    ext_rdata      = '0;
    ext_random     = 1'b0;
    ext_low_cycles = 0;
    eoc_shadow     = '0;  // reset value of the EOC word
    errors         = 0;
    tests_passed   = 0;
    tests_failed   = 0;
    repeat (2) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;

    mark = errors;
    for (int i = 0; i < 8; i++) begin
      bus_access(HOST, 1'b1, 4'hF, `L2_BASE + 4 * i, $urandom);
    end
    bus_access(HOST, 1'b1, 4'b0101, `L2_BASE + 4, 32'hAABB_CCDD);
    bus_access(HOST, 1'b1, 4'b1000, `L2_BASE + 8, 32'h1122_3344);
    bus_access(HOST, 1'b1, 4'hF, `L2_BASE + 4 * (`L2_WORDS + 3), 32'hCAFE_0003);
    bus_access(HOST, 1'b1, 4'b0010, `L2_BASE + 4 * (7 * `L2_WORDS + 5), 32'h0000_7700);
    for (int i = 0; i < 8; i++) begin
      bus_access(HOST, 1'b0, 4'hF, `L2_BASE + 4 * i, '0);
    end
    bus_access(HOST, 1'b0, 4'hF, `L2_BASE + 4 * (3 * `L2_WORDS + 2), '0);
    finish_test("test 1 L2 write and read from the host", mark);

    mark = errors;
    for (int i = 0; i < 8; i++) begin
      bus_access(HOST, 1'b0, 4'hF, `CTRL_BASE + 4 * i, '0);
    end
    finish_test("test 2 control register reads", mark);

    mark = errors;
    bus_access(HOST, 1'b1, 4'hF, `CTRL_BASE + 4 * mempool_ctrl_pkg::REG_WAKE_UP, 32'hFFFF_FFA5);
    @(posedge clk);
    check_value("wake_up_o", wake_up, 32'hFFFF_FFA5 & ((64'd1 << `NUM_CORES) - 1));
    @(posedge clk);
    check_value("wake_up_o after the pulse", wake_up, '0);
    @(negedge clk);
    check_value("busy_o before fetch", busy, 1'b0);
    fetch_en = 1'b1;
    @(negedge clk);
    fetch_en = 1'b0;
    @(posedge clk);
    check_value("busy_o after fetch", busy, 1'b1);
    @(negedge clk);
    bus_access(HOST, 1'b1, 4'hF, `CTRL_BASE + 4 * mempool_ctrl_pkg::REG_EOC, 32'h0000_2469);
    @(posedge clk);
    check_value("eoc_valid_o", eoc_valid, 1'b1);
    check_value("busy_o after eoc", busy, 1'b0);
    check_value("eoc_o", eoc, 32'h0000_1234);
    @(negedge clk);
    bus_access(HOST, 1'b0, 4'hF, `CTRL_BASE + 4 * mempool_ctrl_pkg::REG_EOC, '0);
    // a later write with bit 0 clear changes the code but not the valid level
    bus_access(HOST, 1'b1, 4'hF, `CTRL_BASE + 4 * mempool_ctrl_pkg::REG_EOC, 32'h0000_0ACE);
    @(posedge clk);
    check_value("eoc_valid_o after a second write", eoc_valid, 1'b1);
    check_value("eoc_o after a second write", eoc, 32'h0000_0567);
    @(negedge clk);
    finish_test("test 3 wake-up, busy and end of computation", mark);

    mark = errors;
    bus_access(HOST, 1'b1, 4'b0110, 32'h1234_5678, 32'hDEAD_BEEF);
    assert (ext_seen === make_req(1'b1, 4'b0110, 32'h1234_5678, 32'hDEAD_BEEF)) else begin
      $display("Mismatch at %0d ns: ext_req_o is %h", $time, ext_seen);
      errors++;
    end
    bus_access(HOST, 1'b0, 4'hF, 32'hC000_0010, '0);
    bus_access(HOST, 1'b0, 4'hF, 32'h0000_0100, '0);
    ext_low_cycles = 6;
    @(negedge clk);
    bus_access(HOST, 1'b0, 4'hF, 32'hF000_0040, '0);
    assert (grant_wait[HOST] >= 4) else begin
      $display("external access went through while its grant was held low");
      errors++;
    end
    ext_random = 1'b1;
    for (int i = 0; i < 8; i++) begin
      bus_access(i % NUM_MST, i[0], 4'hF, {4'h2, 28'(i * 32'h0123_4567)}, $urandom);
    end
    finish_test("test 4 external port", mark);

    mark = errors;
    for (int i = 0; i < 16; i++) begin
      bus_access(HOST, 1'b1, 4'hF, `L2_BASE + 4 * i, $urandom);
    end
    for (int m = 0; m < NUM_MST; m++) begin
      automatic int unsigned mm = m;
      fork
        random_traffic(mm, 24);
      join_none
    end
    wait fork;
    finish_test("test 5 random traffic from all masters", mark);

    assert (i_dut.i_props.fail_count == 0) else begin
      $display("%0d bus protocol assertions failed", i_dut.i_props.fail_count);
      errors++;
    end
    $display("tests passed %0d, failed %0d, errors %0d", tests_passed, tests_failed, errors);
    if (tests_failed == 0 && errors == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

// File: include/mempool_cfg.svh
`ifndef MEMPOOL_CFG_SVH
`define MEMPOOL_CFG_SVH

// cluster size
`define NUM_TILES 4
`define NUM_CORES 8

// depth of the L2 scratch memory in 32-bit words
`define L2_WORDS 256

// system address map, everything outside both ranges goes to the external port
`define CTRL_BASE 32'h4000_0000
`define CTRL_END  32'h4000_FFFF
`define L2_BASE   32'h8000_0000
`define L2_END    32'hBFFF_FFFF

// TCDM window reported through the read-only control registers
`define TCDM_BASE 32'h0000_0000
`define TCDM_SIZE 32'h0001_0000

`endif

// File: mempool_system.f
+incdir+include
verilog/mempool_bus_pkg.sv
verilog/mempool_ctrl_pkg.sv
verilog/mempool_rr_arbiter.sv
verilog/mempool_interconnect.sv
verilog/mempool_l2_mem.sv
verilog/mempool_ctrl_registers.sv
verilog/mempool_system.sv
bench/mempool_system_props.sv
bench/tb_mempool_system.sv

// File: verilog/mempool_bus_pkg.sv
package mempool_bus_pkg;

  // L2 view of a bus address
  typedef struct packed {
    logic [1:0]  region;    // 2'b10 selects the L2 window
    logic [27:0] word_idx;  // wraps modulo the memory depth
    logic [1:0]  byte_off;
  } l2_addr_t;

  // control register view of a bus address
  typedef struct packed {
    logic [15:0] region;    // upper half word of the control window
    logic [10:0] reserved;
    logic [2:0]  reg_idx;
    logic [1:0]  byte_off;
  } ctrl_addr_t;

  // one address word, decoded either way depending on the target
  typedef union packed {
    l2_addr_t   l2;
    ctrl_addr_t ctrl;
  } bus_addr_u;

  typedef struct packed {
    logic        req;
    logic        we;
    logic [3:0]  be;
    bus_addr_u   addr;
    logic [31:0] wdata;
  } bus_req_t;

  typedef struct packed {
    logic        rvalid;  // one cycle after the grant
    logic [31:0] rdata;   // zero for writes
  } bus_rsp_t;

endpackage

// File: verilog/mempool_ctrl_pkg.sv
package mempool_ctrl_pkg;

  // bus targets behind the address decoder
  typedef enum logic [1:0] {
    TGT_CTRL = 2'd0,
    TGT_L2   = 2'd1,
    TGT_EXT  = 2'd2
  } target_e;

  // ******************************************************************
  // control register map, one 32-bit word per index
  // ******************************************************************

  typedef enum logic [2:0] {
    REG_TCDM_START = 3'd0,  // read-only
    REG_TCDM_END   = 3'd1,  // read-only
    REG_NUM_CORES  = 3'd2,  // read-only
    REG_WAKE_UP    = 3'd3,  // write-only, reads return zero
    REG_EOC        = 3'd4   // bit 0 flags end of computation
  } ctrl_reg_e;

endpackage

// File: verilog/mempool_ctrl_registers.sv
`timescale 1ns/1ps
`include "mempool_cfg.svh"

module mempool_ctrl_registers (
  input  logic                      clk_i,
  input  logic                      reset_i,
  input  mempool_bus_pkg::bus_req_t req_i,
  output logic [31:0]               rdata_o,
  input  logic                      fetch_en_i,
  output logic [`NUM_CORES-1:0]     wake_up_o,
  output logic [31:0]               eoc_o,
  output logic                      eoc_valid_o,
  output logic                      busy_o
);

  mempool_ctrl_pkg::ctrl_reg_e reg_sel;
  logic                        wr;
  logic                        rd;
  logic                        eoc_set;

  logic [`NUM_CORES-1:0]       wake_up_q;
  logic [31:0]                 eoc_word_q;
  logic                        eoc_valid_q;
  logic                        busy_q;
  logic [31:0]                 rdata_q;

  assign reg_sel = mempool_ctrl_pkg::ctrl_reg_e'(req_i.addr.ctrl.reg_idx);
  assign wr      = req_i.req && req_i.we;
  assign rd      = req_i.req && !req_i.we;
  assign eoc_set = wr && (reg_sel == mempool_ctrl_pkg::REG_EOC) && req_i.wdata[0];

  // ******************************************************************
  // write side
  // ******************************************************************

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wake_up_q   <= '0;
      eoc_word_q  <= '0;
      eoc_valid_q <= 1'b0;
      busy_q      <= 1'b0;
    end else begin
      wake_up_q <= '0;  // single cycle pulse
      if (wr && reg_sel == mempool_ctrl_pkg::REG_WAKE_UP) begin
        wake_up_q <= req_i.wdata[`NUM_CORES-1:0];
      end
      if (wr && reg_sel == mempool_ctrl_pkg::REG_EOC) begin
        eoc_word_q <= req_i.wdata;
      end
      if (eoc_set) begin
        eoc_valid_q <= 1'b1;  // sticky until reset
        busy_q      <= 1'b0;
      end else if (fetch_en_i && !eoc_valid_q) begin
        busy_q <= 1'b1;
      end
    end
  end

  // read data is returned one cycle after the access
  always_ff @(posedge clk_i) begin
    if (rd) begin
      case (reg_sel)
        mempool_ctrl_pkg::REG_TCDM_START: rdata_q <= `TCDM_BASE;
        mempool_ctrl_pkg::REG_TCDM_END:   rdata_q <= `TCDM_BASE + `TCDM_SIZE - 32'd1;
        mempool_ctrl_pkg::REG_NUM_CORES:  rdata_q <= 32'(`NUM_CORES);
        mempool_ctrl_pkg::REG_EOC:        rdata_q <= eoc_word_q;
        default:                          rdata_q <= '0;
      endcase
    end
  end

  assign rdata_o     = rdata_q;
  assign wake_up_o   = wake_up_q;
  assign eoc_o       = eoc_word_q >> 1;  // bit 0 only carries the valid flag
  assign eoc_valid_o = eoc_valid_q;
  assign busy_o      = busy_q;

endmodule

// File: verilog/mempool_interconnect.sv
`timescale 1ns/1ps
`include "mempool_cfg.svh"

module mempool_interconnect (
  input  logic                                     clk_i,
  input  logic                                     reset_i,
  input  mempool_bus_pkg::bus_req_t [`NUM_TILES:0] mst_req_i,
  output logic                      [`NUM_TILES:0] mst_gnt_o,
  output mempool_bus_pkg::bus_rsp_t [`NUM_TILES:0] mst_rsp_o,
  output mempool_bus_pkg::bus_req_t                ctrl_req_o,
  input  logic                      [31:0]         ctrl_rdata_i,
  output mempool_bus_pkg::bus_req_t                l2_req_o,
  input  logic                      [31:0]         l2_rdata_i,
  output mempool_bus_pkg::bus_req_t                ext_req_o,
  input  logic                                     ext_gnt_i,
  input  logic                      [31:0]         ext_rdata_i
);

  localparam int unsigned NumMst = `NUM_TILES + 1;
  localparam int unsigned IdxW   = $clog2(NumMst);

  localparam logic [31:0] CtrlBase = `CTRL_BASE;
  localparam logic [31:0] CtrlEnd  = `CTRL_END;
  localparam logic [31:0] L2Base   = `L2_BASE;
  localparam logic [31:0] L2End    = `L2_END;

  logic [NumMst-1:0]          req_vec;
  logic [IdxW-1:0]            cand_idx;
  mempool_bus_pkg::bus_req_t  cand;
  mempool_ctrl_pkg::target_e  tgt;
  logic                       any_req;
  logic                       stall;

  logic                       rsp_valid_q;
  logic [IdxW-1:0]            rsp_idx_q;
  mempool_ctrl_pkg::target_e  rsp_tgt_q;
  logic                       rsp_we_q;
  logic [31:0]                rsp_rdata;

  // ******************************************************************
  // arbitration and address decode
  // ******************************************************************

  always_comb begin
    for (int unsigned i = 0; i < NumMst; i++) begin
      req_vec[i] = mst_req_i[i].req;
    end
  end

  assign any_req = |req_vec;
  assign cand    = mst_req_i[cand_idx];

  always_comb begin
    if (cand.addr.ctrl.region >= CtrlBase[31:16] && cand.addr.ctrl.region <= CtrlEnd[31:16]) begin
      tgt = mempool_ctrl_pkg::TGT_CTRL;
    end else if (cand.addr.l2.region >= L2Base[31:30] && cand.addr.l2.region <= L2End[31:30]) begin
      tgt = mempool_ctrl_pkg::TGT_L2;
    end else begin
      tgt = mempool_ctrl_pkg::TGT_EXT;  // default target
    end
  end

  // only the external port can push back
  assign stall = any_req && (tgt == mempool_ctrl_pkg::TGT_EXT) && !ext_gnt_i;

  mempool_rr_arbiter #(
    .NumReq   (NumMst)
  ) i_arbiter (
    .clk_i    (clk_i),
    .reset_i  (reset_i),
    .req_i    (req_vec),
    .stall_i  (stall),
    .gnt_o    (mst_gnt_o),
    .gnt_idx_o(cand_idx)
  );

  // target fan-out, the request strobe reaches exactly one target
  always_comb begin
    ctrl_req_o     = cand;
    l2_req_o       = cand;
    ext_req_o      = cand;
    ctrl_req_o.req = any_req && (tgt == mempool_ctrl_pkg::TGT_CTRL);
    l2_req_o.req   = any_req && (tgt == mempool_ctrl_pkg::TGT_L2);
    ext_req_o.req  = any_req && (tgt == mempool_ctrl_pkg::TGT_EXT);
  end

  // ******************************************************************
  // response return
  // ******************************************************************

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rsp_valid_q <= 1'b0;
    end else begin
      rsp_valid_q <= |mst_gnt_o;
    end
  end

  always_ff @(posedge clk_i) begin
    rsp_idx_q <= cand_idx;
    rsp_tgt_q <= tgt;
    rsp_we_q  <= cand.we;
  end

  always_comb begin
    case (rsp_tgt_q)
      mempool_ctrl_pkg::TGT_CTRL: rsp_rdata = ctrl_rdata_i;
      mempool_ctrl_pkg::TGT_L2:   rsp_rdata = l2_rdata_i;
      default:                    rsp_rdata = ext_rdata_i;
    endcase
    if (rsp_we_q) begin
      rsp_rdata = '0;  // writes answer with zero data
    end
  end

  always_comb begin
    for (int unsigned i = 0; i < NumMst; i++) begin
      mst_rsp_o[i].rvalid = rsp_valid_q && (rsp_idx_q == IdxW'(i));
      mst_rsp_o[i].rdata  = mst_rsp_o[i].rvalid ? rsp_rdata : '0;
    end
  end

endmodule

// File: verilog/mempool_l2_mem.sv
`timescale 1ns/1ps
`include "mempool_cfg.svh"

module mempool_l2_mem (
  input  logic                      clk_i,
  input  mempool_bus_pkg::bus_req_t req_i,
  output logic [31:0]               rdata_o
);

  localparam int unsigned Depth = `L2_WORDS;
  localparam int unsigned AddrW = (Depth > 1) ? $clog2(Depth) : 1;

  logic [31:0]      mem_q [Depth];
  logic [31:0]      rdata_q;
  logic [AddrW-1:0] word_idx;

  // upper index bits are dropped so the window wraps over the array
  assign word_idx = req_i.addr.l2.word_idx[AddrW-1:0];

  // ******************************************************************
  // single port array with byte enables
  // ******************************************************************

  always_ff @(posedge clk_i) begin
    if (req_i.req && req_i.we) begin
      for (int unsigned b = 0; b < 4; b++) begin
        if (req_i.be[b]) begin
          mem_q[word_idx][8*b +: 8] <= req_i.wdata[8*b +: 8];
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_i.req && !req_i.we) begin
      rdata_q <= mem_q[word_idx];  // answer in the cycle after the request
    end
  end

  assign rdata_o = rdata_q;

endmodule

// File: verilog/mempool_rr_arbiter.sv
`timescale 1ns/1ps

module mempool_rr_arbiter #(
  parameter int unsigned NumReq = 5
) (
  input  logic                   clk_i,
  input  logic                   reset_i,
  input  logic [NumReq-1:0]      req_i,
  input  logic                   stall_i,
  output logic [NumReq-1:0]      gnt_o,
  output logic [((NumReq > 1) ? $clog2(NumReq) : 1)-1:0] gnt_idx_o
);

  localparam int unsigned IdxW = (NumReq > 1) ? $clog2(NumReq) : 1;

  logic [IdxW-1:0] prio_q;
  logic [IdxW-1:0] prio_d;
  logic [IdxW-1:0] win_idx;
  logic            found;

  // first requester at or after the priority pointer
  always_comb begin
    int unsigned idx;
    found   = 1'b0;
    win_idx = '0;
    for (int unsigned i = 0; i < NumReq; i++) begin
      idx = prio_q + i;
      if (idx >= NumReq) begin
        idx = idx - NumReq;
      end
      if (!found && req_i[idx]) begin
        found   = 1'b1;
        win_idx = IdxW'(idx);
      end
    end
  end

  always_comb begin
    gnt_o = '0;
    if (found && !stall_i) begin
      gnt_o[win_idx] = 1'b1;
    end
  end

  assign gnt_idx_o = win_idx;  // the candidate, also while stalled
  assign prio_d    = (win_idx == IdxW'(NumReq - 1)) ? '0 : win_idx + 1'b1;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      prio_q <= '0;
    end else if (found && !stall_i) begin
      prio_q <= prio_d;  // winner drops to lowest priority
    end
  end

endmodule

// File: verilog/mempool_system.sv
`timescale 1ns/1ps
`include "mempool_cfg.svh"

module mempool_system (
  input  logic                                       clk_i,
  input  logic                                       reset_i,
  input  logic                                       fetch_en_i,
  input  mempool_bus_pkg::bus_req_t [`NUM_TILES-1:0] tile_req_i,
  output logic                      [`NUM_TILES-1:0] tile_gnt_o,
  output mempool_bus_pkg::bus_rsp_t [`NUM_TILES-1:0] tile_rsp_o,
  input  mempool_bus_pkg::bus_req_t                  host_req_i,
  output logic                                       host_gnt_o,
  output mempool_bus_pkg::bus_rsp_t                  host_rsp_o,
  output mempool_bus_pkg::bus_req_t                  ext_req_o,
  input  logic                                       ext_gnt_i,
  input  logic                      [31:0]           ext_rdata_i,
  output logic                      [`NUM_CORES-1:0] wake_up_o,
  output logic                      [31:0]           eoc_o,
  output logic                                       eoc_valid_o,
  output logic                                       busy_o
);

  localparam int unsigned NumMst = `NUM_TILES + 1;

  mempool_bus_pkg::bus_req_t [NumMst-1:0] mst_req;
  logic                      [NumMst-1:0] mst_gnt;
  mempool_bus_pkg::bus_rsp_t [NumMst-1:0] mst_rsp;
  mempool_bus_pkg::bus_req_t              ctrl_req;
  mempool_bus_pkg::bus_req_t              l2_req;
  logic                      [31:0]       ctrl_rdata;
  logic                      [31:0]       l2_rdata;

  // the host sits above the tiles as the last master
  assign mst_req    = {host_req_i, tile_req_i};
  assign tile_gnt_o = mst_gnt[NumMst-2:0];
  assign host_gnt_o = mst_gnt[NumMst-1];
  assign tile_rsp_o = mst_rsp[NumMst-2:0];
  assign host_rsp_o = mst_rsp[NumMst-1];

  // ******************************************************************
  // system bus and its targets
  // ******************************************************************

  mempool_interconnect i_interconnect (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .mst_req_i   (mst_req),
    .mst_gnt_o   (mst_gnt),
    .mst_rsp_o   (mst_rsp),
    .ctrl_req_o  (ctrl_req),
    .ctrl_rdata_i(ctrl_rdata),
    .l2_req_o    (l2_req),
    .l2_rdata_i  (l2_rdata),
    .ext_req_o   (ext_req_o),
    .ext_gnt_i   (ext_gnt_i),
    .ext_rdata_i (ext_rdata_i)
  );

  mempool_l2_mem i_l2_mem (
    .clk_i  (clk_i),
    .req_i  (l2_req),
    .rdata_o(l2_rdata)
  );

  mempool_ctrl_registers i_ctrl_registers (
    .clk_i      (clk_i),
    .reset_i    (reset_i),
    .req_i      (ctrl_req),
    .rdata_o    (ctrl_rdata),
    .fetch_en_i (fetch_en_i),
    .wake_up_o  (wake_up_o),
    .eoc_o      (eoc_o),
    .eoc_valid_o(eoc_valid_o),
    .busy_o     (busy_o)
  );

endmodule
